// File: Makefile
VERILATOR ?= verilator
TOP       ?= tag_chain_tb
FILELIST  ?= tag_chain.f
FLAGS     ?= --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove obj_dir"

test:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tag_chain.f
+incdir+verilog
verilog/tag_bus_pkg.sv
verilog/tag_replay_pkg.sv
verilog/tag_cmd_receiver.sv
verilog/tag_trace_replay.sv
verilog/tag_client.sv
verilog/tag_chain_top.sv
tests/tag_chain_tb.sv

// File: tests/tag_chain_tb.sv
`timescale 1ns/1ns

`include "tag_consts.svh"

module tag_chain_tb;

  import tag_bus_pkg::*;

  typedef logic [`TAG_NUM_CLIENTS-1:0][`TAG_PAYLOAD_WIDTH-1:0] cfg_t;

  // One frame as seen on the line plus the outputs on the cycle after it
  typedef struct packed
  {
    logic [15:0]                  bits;
    int                           len;
    logic [`TAG_NUM_CLIENTS-1:0]  upd;
    cfg_t                         cfg;
  } frame_rec_s;

  localparam int timeout_lp = 200;

  logic                         clk;
  logic                         rst_n;
  logic                         cmd_req;
  tag_cmd_s                     cmd;
  logic                         cmd_ack;
  logic                         tag_en;
  logic                         tag_data;
  cfg_t                         config_val;
  logic [`TAG_NUM_CLIENTS-1:0]  updated;
  logic                         done;

  integer       seed;
  cfg_t         model;
  tag_cmd_s     exp_q[$];
  frame_rec_s   got_q[$];
  frame_rec_s   seen_rec;
  logic [15:0]  bits;
  int           bit_cnt;
  int           upd_pulses;
  int           frames_checked;
  logic         done_sent;
  logic         done_seen;
  event         frame_ev;

  tag_chain_top i_tag_chain_top
  (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .cmd_req_i  (cmd_req),
    .cmd_i      (cmd),
    .cmd_ack_o  (cmd_ack),
    .tag_en_o   (tag_en),
    .tag_data_o (tag_data),
    .config_o   (config_val),
    .updated_o  (updated),
    .done_o     (done)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic cfg_t next_config(input cfg_t cur, input tag_cmd_s c);
    cfg_t nxt;
    nxt = cur;
    if (c.op == TAG_OP_WRITE)
      nxt[c.id] = c.payload;
    else if (c.op == TAG_OP_CLEAR)
      nxt[c.id] = '0;
    return nxt;
  endfunction

  // Start bit, id LSB first, opcode bit, payload LSB first
  function automatic logic [`TAG_FRAME_LEN-1:0] expected_frame(input tag_cmd_s c);
    logic [`TAG_FRAME_LEN-1:0] f;
    f[0] = 1'b1;
    for (int i = 0; i < `TAG_ID_WIDTH; i++)
      f[1 + i] = c.id[i];
    f[1 + `TAG_ID_WIDTH] = (c.op == TAG_OP_CLEAR);
    for (int i = 0; i < `TAG_PAYLOAD_WIDTH; i++)
      f[2 + `TAG_ID_WIDTH + i] = c.payload[i];
    return f;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
      stop_run($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Four-phase handshake with the receiver
  // Frames are expected only before DONE
  task automatic send_cmd(input tag_cmd_s c);
    int t;
    if (!done_sent && c.op != TAG_OP_DONE)
      exp_q.push_back(c);
    if (c.op == TAG_OP_DONE)
      done_sent = 1'b1;
    @(posedge clk);
    cmd     <= c;
    cmd_req <= 1'b1;
    for (t = 0; !cmd_ack; t++)
    begin
      if (t == timeout_lp)
        stop_run("Timeout waiting for cmd_ack_o to rise");
      @(negedge clk);
    end
    @(posedge clk);
    cmd_req <= 1'b0;
    for (t = 0; cmd_ack; t++)
    begin
      if (t == timeout_lp)
        stop_run("Timeout waiting for cmd_ack_o to fall");
      @(negedge clk);
    end
  endtask

  task automatic wait_frames_drained();
    for (int t = 0; exp_q.size() != 0; t++)
    begin
      if (t == timeout_lp * 4)
        stop_run("Timeout waiting for the pending frames on the tag line");
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Frame monitor and compare
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (updated != '0)
        upd_pulses++;
      assert (!done_seen || done)
      else
        stop_run("done_o dropped after it was raised");
      if (tag_en)
      begin
        if (bit_cnt < 16)
          bits[bit_cnt] = tag_data;
        bit_cnt++;
      end
      else if (bit_cnt != 0)
      begin
        seen_rec.bits = bits;
        seen_rec.len  = bit_cnt;
        seen_rec.upd  = updated;
        seen_rec.cfg  = config_val;
        got_q.push_back(seen_rec);
        bits    = '0;
        bit_cnt = 0;
        -> frame_ev;
      end
    end
  end

  initial
  begin
    tag_cmd_s   c;
    frame_rec_s r;
    forever
    begin
      @(frame_ev);
      while (got_q.size() != 0)
      begin
        r = got_q.pop_front();
        assert (exp_q.size() != 0)
        else
          stop_run("A frame appeared on the tag line with no command pending");
        c     = exp_q.pop_front();
        model = next_config(model, c);
        check_value("tag_en_o length", r.len, `TAG_FRAME_LEN);
        check_value("tag_data_o frame", r.bits, expected_frame(c));
        check_value("updated_o", r.upd, 1 << c.id);
        check_value("config_o", r.cfg, model);
        frames_checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    tag_cmd_s c;
    clk            = 1'b0;
    rst_n          = 1'b0;
    cmd_req        = 1'b0;
    cmd            = '0;
    seed           = 18;
    model          = '0;
    bits           = '0;
    bit_cnt        = 0;
    upd_pulses     = 0;
    frames_checked = 0;
    done_sent      = 1'b0;
    done_seen      = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_value("cmd_ack_o", cmd_ack, 0);
    check_value("tag_en_o", tag_en, 0);
    check_value("updated_o", updated, 0);
    check_value("done_o", done, 0);
    check_value("config_o", config_val, 0);

    // One write per client and then a clear of a single client
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
    begin
      c.op      = TAG_OP_WRITE;
      c.id      = `TAG_ID_WIDTH'(i);
      c.payload = `TAG_PAYLOAD_WIDTH'(i * 67 + 29);
      send_cmd(c);
    end
    wait_frames_drained();
    c.op      = TAG_OP_CLEAR;
    c.id      = `TAG_ID_WIDTH'(2);
    c.payload = 8'hff;
    send_cmd(c);
    wait_frames_drained();

    // Back to back commands so the one-entry buffer stalls the host
    repeat (40)
    begin
      c.op      = (($random(seed) & 3) == 0) ? TAG_OP_CLEAR : TAG_OP_WRITE;
      c.id      = `TAG_ID_WIDTH'($random(seed));
      c.payload = `TAG_PAYLOAD_WIDTH'($random(seed));
      send_cmd(c);
    end
    wait_frames_drained();

    c.op = TAG_OP_DONE;
    send_cmd(c);
    for (int t = 0; !done; t++)
    begin
      if (t == timeout_lp)
        stop_run("Timeout waiting for done_o to rise");
      @(negedge clk);
    end
    done_seen = 1'b1;

    // A write after DONE is swallowed and sends no frame
    c.op      = TAG_OP_WRITE;
    c.id      = `TAG_ID_WIDTH'(1);
    c.payload = 8'h99;
    send_cmd(c);
    repeat (2 * `TAG_FRAME_LEN) @(negedge clk);

    check_value("config_o", config_val, model);
    check_value("updated_o pulse count", upd_pulses, frames_checked);
    check_value("done_o", done, 1);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/tag_bus_pkg.sv
`include "tag_consts.svh"

package tag_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Host command format
  ////////////////////////////////////////////////////////////////////////////

  // Host level opcodes
  // Only WRITE and CLEAR reach the serial line, DONE stays in the engine
  typedef enum logic [1:0]
  {
    TAG_OP_WRITE = 2'd0,
    TAG_OP_CLEAR = 2'd1,
    TAG_OP_DONE  = 2'd2
  } tag_op_e;

  // One configuration command as handed over by the host
  typedef struct packed
  {
    tag_op_e                        op;
    logic [`TAG_ID_WIDTH-1:0]       id;
    logic [`TAG_PAYLOAD_WIDTH-1:0]  payload;
  } tag_cmd_s;

endpackage

// File: verilog/tag_chain_top.sv
`timescale 1ns/1ns

`include "tag_consts.svh"

module tag_chain_top
(
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  cmd_req_i,
  input  tag_bus_pkg::tag_cmd_s                                 cmd_i,
  output logic                                                  cmd_ack_o,
  output logic                                                  tag_en_o,
  output logic                                                  tag_data_o,
  output logic [`TAG_NUM_CLIENTS-1:0][`TAG_PAYLOAD_WIDTH-1:0]   config_o,
  output logic [`TAG_NUM_CLIENTS-1:0]                           updated_o,
  output logic                                                  done_o
);

  import tag_bus_pkg::*;

  logic     buf_valid;
  tag_cmd_s buf_cmd;
  logic     buf_take;
  logic     tag_en;
  logic     tag_data;

  tag_cmd_receiver i_tag_cmd_receiver
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .cmd_ack_o   (cmd_ack_o),
    .buf_valid_o (buf_valid),
    .buf_cmd_o   (buf_cmd),
    .buf_take_i  (buf_take)
  );

  tag_trace_replay i_tag_trace_replay
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .buf_valid_i (buf_valid),
    .buf_cmd_i   (buf_cmd),
    .buf_take_o  (buf_take),
    .tag_en_o    (tag_en),
    .tag_data_o  (tag_data),
    .done_o      (done_o)
  );

  // All clients share the line, each answers to its own index
  for (genvar i = 0; i < `TAG_NUM_CLIENTS; i++)
  begin : g_client
    tag_client #(.client_id_p(`TAG_ID_WIDTH'(i))) i_tag_client
    (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .tag_en_i   (tag_en),
      .tag_data_i (tag_data),
      .config_o   (config_o[i]),
      .updated_o  (updated_o[i])
    );
  end

  assign tag_en_o   = tag_en;
  assign tag_data_o = tag_data;

endmodule

// File: verilog/tag_client.sv
`timescale 1ns/1ns

`include "tag_consts.svh"

module tag_client
#(
  parameter logic [`TAG_ID_WIDTH-1:0] client_id_p = '0
)
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          tag_en_i,
  input  logic                          tag_data_i,
  output logic [`TAG_PAYLOAD_WIDTH-1:0] config_o,
  output logic                          updated_o
);

  import tag_replay_pkg::*;

  localparam frame_pos_t last_pos_lp = frame_pos_t'(`TAG_FRAME_LEN - 1);
  localparam int op_idx_lp = 1 + `TAG_ID_WIDTH;

  frame_pos_t                     pos_r;
  logic [`TAG_FRAME_LEN-2:0]      shift_r;
  logic [`TAG_FRAME_LEN-1:0]      frame_w;
  logic                           frame_done;
  logic                           hit;
  logic [`TAG_PAYLOAD_WIDTH-1:0]  config_r;
  logic                           updated_r;

  // Earlier bits plus the bit on the line now, start bit at index 0
  assign frame_w    = {tag_data_i, shift_r};
  assign frame_done = tag_en_i && (pos_r == last_pos_lp);

  // Valid start bit and our own address
  assign hit = frame_w[0] && (frame_w[`TAG_ID_WIDTH:1] == client_id_p);

  always_ff @(posedge clk_i)
  begin
    if (tag_en_i)
      shift_r <= {tag_data_i, shift_r[`TAG_FRAME_LEN-2:1]};
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pos_r     <= '0;
      config_r  <= '0;
      updated_r <= 1'b0;
    end
    else
    begin
      if (!tag_en_i || frame_done)
        pos_r <= '0;
      else
        pos_r <= pos_r + 1'b1;

      // Register and pulse show up the cycle after the last bit
      updated_r <= frame_done && hit;
      if (frame_done && hit)
      begin
        if (frame_w[op_idx_lp])
          config_r <= '0;
        else
          config_r <= frame_w[`TAG_FRAME_LEN-1:op_idx_lp+1];
      end
    end
  end

  assign config_o  = config_r;
  assign updated_o = updated_r;

  a_upd_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    updated_o |=> !updated_o);

endmodule

// File: verilog/tag_cmd_receiver.sv
`timescale 1ns/1ns

module tag_cmd_receiver
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cmd_req_i,
  input  tag_bus_pkg::tag_cmd_s cmd_i,
  output logic                  cmd_ack_o,
  output logic                  buf_valid_o,
  output tag_bus_pkg::tag_cmd_s buf_cmd_o,
  input  logic                  buf_take_i
);

  import tag_bus_pkg::*;

  logic     ack_r;
  logic     valid_r;
  tag_cmd_s cmd_r;
  logic     capture;

  // New request, previous handshake closed and room in the buffer
  // A full buffer holds the host off by withholding the ack
  assign capture = cmd_req_i && !ack_r && !valid_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_r   <= 1'b0;
      valid_r <= 1'b0;
    end
    else
    begin
      if (capture)
        ack_r <= 1'b1;
      else if (!cmd_req_i)
        ack_r <= 1'b0;

      if (capture)
        valid_r <= 1'b1;
      else if (buf_take_i)
        valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (capture)
      cmd_r <= cmd_i;
  end

  assign cmd_ack_o   = ack_r;
  assign buf_valid_o = valid_r;
  assign buf_cmd_o   = cmd_r;

  // Ack only drops once the host has released its request
  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(cmd_ack_o) |-> $past(!cmd_req_i));

endmodule

// File: verilog/tag_consts.svh
`ifndef TAG_CONSTS_SVH
`define TAG_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Tag chain sizing
////////////////////////////////////////////////////////////////////////////

// Clients on the serial tag line
`define TAG_NUM_CLIENTS 4

// Client address width, enough for TAG_NUM_CLIENTS
`define TAG_ID_WIDTH 2

// Configuration register width
`define TAG_PAYLOAD_WIDTH 8

// Start bit, id bits, opcode bit and payload bits
`define TAG_FRAME_LEN (1 + `TAG_ID_WIDTH + 1 + `TAG_PAYLOAD_WIDTH)

`endif

// File: verilog/tag_replay_pkg.sv
`include "tag_consts.svh"

package tag_replay_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Replay engine internals
  ////////////////////////////////////////////////////////////////////////////

  // Engine FSM
  // DONE is sticky until reset
  typedef enum logic [1:0]
  {
    REPLAY_IDLE = 2'd0,
    REPLAY_SEND = 2'd1,
    REPLAY_DONE = 2'd2
  } replay_state_e;

  // Bit position inside a serial frame, shared with the clients
  typedef logic [$clog2(`TAG_FRAME_LEN)-1:0] frame_pos_t;

endpackage

// File: verilog/tag_trace_replay.sv
`timescale 1ns/1ns

`include "tag_consts.svh"

module tag_trace_replay
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  buf_valid_i,
  input  tag_bus_pkg::tag_cmd_s buf_cmd_i,
  output logic                  buf_take_o,
  output logic                  tag_en_o,
  output logic                  tag_data_o,
  output logic                  done_o
);

  import tag_bus_pkg::*;
  import tag_replay_pkg::*;

  localparam frame_pos_t last_pos_lp = frame_pos_t'(`TAG_FRAME_LEN - 1);

  replay_state_e              state_r;
  frame_pos_t                 pos_r;
  logic                       tag_en_r;
  logic [`TAG_FRAME_LEN-1:0]  frame_r;
  logic [`TAG_FRAME_LEN-1:0]  frame_next;
  logic                       op_bit;
  logic                       load;

  ////////////////////////////////////////////////////////////////////////////
  // Command intake
  ////////////////////////////////////////////////////////////////////////////

  // Commands are taken whenever no frame is on the line
  // In DONE they are swallowed so the host handshake keeps moving
  assign buf_take_o = buf_valid_i && (state_r != REPLAY_SEND);

  assign load = buf_take_o && (state_r == REPLAY_IDLE) && (buf_cmd_i.op != TAG_OP_DONE);

  // Opcode bit on the line is 0 for write and 1 for clear
  assign op_bit = (buf_cmd_i.op == TAG_OP_CLEAR);

  // LSB goes out first with start, id, opcode and payload in that order
  assign frame_next = {buf_cmd_i.payload, op_bit, buf_cmd_i.id, 1'b1};

  ////////////////////////////////////////////////////////////////////////////
  // FSM and bit counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r  <= REPLAY_IDLE;
      pos_r    <= '0;
      tag_en_r <= 1'b0;
    end
    else
    begin
      case (state_r)
        REPLAY_IDLE:
        begin
          if (buf_take_o)
          begin
            if (buf_cmd_i.op == TAG_OP_DONE)
              state_r <= REPLAY_DONE;
            else
            begin
              state_r  <= REPLAY_SEND;
              pos_r    <= '0;
              tag_en_r <= 1'b1;
            end
          end
        end
        REPLAY_SEND:
        begin
          if (pos_r == last_pos_lp)
          begin
            state_r  <= REPLAY_IDLE;
            tag_en_r <= 1'b0;
          end
          else
            pos_r <= pos_r + 1'b1;
        end
        REPLAY_DONE:
          state_r <= REPLAY_DONE;
        default:
          state_r <= REPLAY_IDLE;
      endcase
    end
  end

  // Frame shifter with bit 0 on the line
  always_ff @(posedge clk_i)
  begin
    if (load)
      frame_r <= frame_next;
    else if (tag_en_r)
      frame_r <= frame_r >> 1;
  end

  assign tag_en_o   = tag_en_r;
  // Line idles low between frames
  assign tag_data_o = tag_en_r & frame_r[0];
  assign done_o     = (state_r == REPLAY_DONE);

  a_en_in_send: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tag_en_o |-> (state_r == REPLAY_SEND));

  // The receiver must empty its buffer on the take
  a_take_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    buf_take_o |=> !buf_valid_i);

endmodule
